// ==== list.f ====
common/pgwr_pkg.sv
common/tbl_wr_if.sv
pgwr/entry_counter.sv
pgwr/tbl_beat_builder.sv
pgwr/bresp_tracker.sv
pgwr/pgwr_fsm.sv
rtl/pgwr_mngr.sv
sim/pgwr_assert.sv
sim/pgwr_tb.sv

// ==== Bender.yml ====
package:
  name: pgwr_mngr

sources:
  - common/pgwr_pkg.sv
  - common/tbl_wr_if.sv
  - pgwr/entry_counter.sv
  - pgwr/tbl_beat_builder.sv
  - pgwr/bresp_tracker.sv
  - pgwr/pgwr_fsm.sv
  - rtl/pgwr_mngr.sv
  - target: simulation
    files:
      - sim/pgwr_assert.sv
      - sim/pgwr_tb.sv

// ==== sim/pgwr_tb.sv ====
// testbench for the page-write manager: stimulus table applied in a loop
// bus model with random ready stalls, delayed in-order responses and a shadow memory
// typed compare tasks, error counters, watchdog
`timescale 1ns/1ps

module pgwr_tb;
	localparam int N_OPS       = 6;
	localparam int ATT_LINES   = pgwr_pkg::ATT_ENTRY_CNT / pgwr_pkg::ATT_PER_LINE;
	localparam int LST_LINES   = pgwr_pkg::LIST_ENTRY_CNT / pgwr_pkg::LST_PER_LINE;
	localparam int WDOG_CYCLES = N_OPS * pgwr_pkg::ATT_ENTRY_CNT * 200;

	// one operation and what the flags look like once it has ended
	typedef struct packed {
		pgwr_pkg::wr_kind_e kind;
		pgwr_pkg::idx_t     id;
		pgwr_pkg::att_sts_e sts;
		pgwr_pkg::way_t     way;
		pgwr_pkg::zpd_t     zpd;
		logic               force_err;     // answer its writes with SLVERR
		logic               exp_att_done;
		logic               exp_list_done;
		logic               exp_bus_err;
	} op_row_t;

	logic               clk_i = 1'b0;
	logic               rst_ni;
	logic               init_att;
	logic               init_list;
	logic               att_upd;
	pgwr_pkg::idx_t     att_upd_id;
	pgwr_pkg::att_sts_e att_upd_sts;
	pgwr_pkg::way_t     att_upd_way;
	pgwr_pkg::zpd_t     att_upd_zpd;
	logic               awready;
	logic               wready;
	logic               bvalid;
	pgwr_pkg::bresp_e   bresp;
	logic               awvalid;
	logic               wvalid;
	pgwr_pkg::addr_t    addr;
	pgwr_pkg::line_t    data;
	pgwr_pkg::strb_t    strb;
	logic               ready;
	logic               init_att_done;
	logic               init_list_done;
	logic               tbl_update_done;
	pgwr_pkg::idx_t     free_list_head;
	pgwr_pkg::idx_t     free_list_tail;
	logic               bus_error;

	pgwr_pkg::line_t       att_mem [ATT_LINES]; // shadow of the att lines
	pgwr_pkg::line_t       lst_mem [LST_LINES];
	pgwr_pkg::att_entry_t  exp_att [1:pgwr_pkg::ATT_ENTRY_CNT];
	pgwr_pkg::list_entry_t exp_lst [1:pgwr_pkg::LIST_ENTRY_CNT];
	op_row_t               ops [N_OPS];
	logic                  rsp_err [$]; // pending responses, oldest first
	pgwr_pkg::addr_t       aw_addr;     // last accepted address
	logic                  force_err;
	int                    upd_pulses;
	int                    n_mismatch;
	int                    n_other;

	pgwr_mngr i_dut (.*);

	always #2 clk_i = ~clk_i; // 4 ns period

	function automatic pgwr_pkg::addr_t fill_word(input pgwr_pkg::addr_t a);
		return ~a ^ {a[31:0], a[63:32]}; // every address bit shows up
	endfunction

	// flags: {force_err, att_done, list_done, bus_err}
	function automatic op_row_t make_row(input pgwr_pkg::wr_kind_e kind, input int id,
	                                     input pgwr_pkg::att_sts_e sts, input pgwr_pkg::way_t way,
	                                     input pgwr_pkg::zpd_t zpd, input logic [3:0] flags);
		op_row_t row;
		row.kind          = kind;
		row.id            = pgwr_pkg::idx_t'(id);
		row.sts           = sts;
		row.way           = way;
		row.zpd           = zpd;
		{row.force_err, row.exp_att_done, row.exp_list_done, row.exp_bus_err} = flags;
		return row;
	endfunction

	function automatic pgwr_pkg::line_t merge(input pgwr_pkg::line_t old, input pgwr_pkg::line_t d,
	                                          input pgwr_pkg::strb_t s);
		int b;
		for (b = 0; b < pgwr_pkg::LINE_BYTES; b++) begin
			if (s[b]) old[b*8 +: 8] = d[b*8 +: 8]; // byte lanes with strobe only
		end
		return old;
	endfunction

	function automatic pgwr_pkg::att_entry_t att_slot(input int i);
		int l;
		int s;
		l = (i - 1) / pgwr_pkg::ATT_PER_LINE;
		s = (i - 1) % pgwr_pkg::ATT_PER_LINE;
		return att_mem[l][s*pgwr_pkg::ATT_BITS +: pgwr_pkg::ATT_BITS];
	endfunction

	function automatic pgwr_pkg::list_entry_t lst_slot(input int i);
		int l;
		int s;
		l = (i - 1) / pgwr_pkg::LST_PER_LINE;
		s = (i - 1) % pgwr_pkg::LST_PER_LINE;
		return lst_mem[l][s*pgwr_pkg::LST_BITS +: pgwr_pkg::LST_BITS];
	endfunction

	task automatic check_att(input int i, input pgwr_pkg::att_entry_t got,
	                         input pgwr_pkg::att_entry_t exp);
		if (got !== exp) begin
			n_mismatch++;
			$display("Mismatch at %0t: att entry %0d is %h, expected %h", $time, i, got, exp);
		end
	endtask

	task automatic check_list(input int i, input pgwr_pkg::list_entry_t got,
	                          input pgwr_pkg::list_entry_t exp);
		if (got !== exp) begin
			n_mismatch++;
			$display("Mismatch at %0t: list entry %0d is %h, expected %h", $time, i, got, exp);
		end
	endtask

	task automatic check_idx(input string name, input pgwr_pkg::idx_t got, input pgwr_pkg::idx_t exp);
		if (got !== exp) begin
			n_mismatch++;
			$display("Mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			n_mismatch++;
			$display("Mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			n_mismatch++;
			$display("Mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic store_beat(input pgwr_pkg::addr_t a, input pgwr_pkg::line_t d,
	                          input pgwr_pkg::strb_t s);
		int line;
		if (a >= pgwr_pkg::ATT_BASE && a < pgwr_pkg::ATT_BASE + ATT_LINES * 64 && a[5:0] == 0) begin
			line = int'((a - pgwr_pkg::ATT_BASE) >> pgwr_pkg::LINE_SHIFT);
			check_count("att strobe bytes", $countones(s), pgwr_pkg::ATT_BYTES);
			att_mem[line] = merge(att_mem[line], d, s);
		end else if (a >= pgwr_pkg::LIST_BASE && a < pgwr_pkg::LIST_BASE + LST_LINES * 64 &&
		             a[5:0] == 0) begin
			line = int'((a - pgwr_pkg::LIST_BASE) >> pgwr_pkg::LINE_SHIFT);
			check_count("list strobe bytes", $countones(s), pgwr_pkg::LST_BYTES);
			lst_mem[line] = merge(lst_mem[line], d, s);
		end else begin
			n_other++;
			$display("Error at %0t: write to address %h outside both tables", $time, a);
		end
	endtask

	// fill pattern in the shadow and in the expected entries
	task automatic init_shadow();
		int l;
		int w;
		pgwr_pkg::addr_t a;
		for (l = 0; l < ATT_LINES; l++) begin
			for (w = 0; w < 8; w++) att_mem[l][w*64 +: 64] = fill_word(pgwr_pkg::ATT_BASE + l*64 + w*8);
		end
		for (l = 0; l < LST_LINES; l++) begin
			for (w = 0; w < 8; w++) lst_mem[l][w*64 +: 64] = fill_word(pgwr_pkg::LIST_BASE + l*64 + w*8);
		end
		for (l = 1; l <= pgwr_pkg::ATT_ENTRY_CNT; l++) begin
			exp_att[l] = pgwr_pkg::att_entry_t'(fill_word(pgwr_pkg::ATT_BASE + (l - 1) * 8));
		end
		for (l = 1; l <= pgwr_pkg::LIST_ENTRY_CNT; l++) begin
			a          = pgwr_pkg::LIST_BASE + (l - 1) * 16;
			exp_lst[l] = {fill_word(a + 8), fill_word(a)}; // upper word at the higher address
		end
	endtask

	task automatic run_op(input op_row_t row);
		@(posedge clk_i);
		upd_pulses  = 0;
		force_err   = row.force_err;
		att_upd_id  <= row.id; // held until the next row
		att_upd_sts <= row.sts;
		att_upd_way <= row.way;
		att_upd_zpd <= row.zpd;
		init_att    <= (row.kind == pgwr_pkg::WK_ATT_INIT);
		init_list   <= (row.kind == pgwr_pkg::WK_LIST_INIT);
		att_upd     <= (row.kind == pgwr_pkg::WK_ATT_UPD);
		@(negedge clk_i);
		while (ready) @(negedge clk_i); // accepted once ready drops
		@(posedge clk_i);
		init_att  <= 1'b0;
		init_list <= 1'b0;
		att_upd   <= 1'b0;
		@(negedge clk_i);
		while (!ready) @(negedge clk_i); // operation over
	endtask

	task automatic check_row(input op_row_t row);
		int i;
		unique case (row.kind)
			pgwr_pkg::WK_ATT_INIT: begin
				for (i = 1; i <= pgwr_pkg::ATT_ENTRY_CNT; i++) begin
					exp_att[i]     = '0;
					exp_att[i].sts = pgwr_pkg::STS_DALLOC;
					if (pgwr_pkg::PWRUP_UNCOMP && i <= pgwr_pkg::LIST_ENTRY_CNT) begin
						exp_att[i].sts = pgwr_pkg::STS_UNCOMP;
						exp_att[i].way = pgwr_pkg::PPA_BASE + pgwr_pkg::way_t'(i - 1);
					end
				end
			end
			pgwr_pkg::WK_LIST_INIT: begin
				for (i = 1; i <= pgwr_pkg::LIST_ENTRY_CNT; i++) begin
					exp_lst[i]      = '0;
					exp_lst[i].way  = pgwr_pkg::PPA_BASE + pgwr_pkg::way_t'(i - 1);
					exp_lst[i].prev = pgwr_pkg::ptr_t'(i - 1);
					exp_lst[i].next = (i == pgwr_pkg::LIST_ENTRY_CNT) ? '0 : pgwr_pkg::ptr_t'(i + 1);
				end
			end
			default: begin
				exp_att[row.id].zpd_cnt = row.zpd; // only this slot changes
				exp_att[row.id].way     = row.way;
				exp_att[row.id].sts     = row.sts;
			end
		endcase
		for (i = 1; i <= pgwr_pkg::ATT_ENTRY_CNT; i++) check_att(i, att_slot(i), exp_att[i]);
		for (i = 1; i <= pgwr_pkg::LIST_ENTRY_CNT; i++) check_list(i, lst_slot(i), exp_lst[i]);
		check_flag("init_att_done", init_att_done, row.exp_att_done);
		check_flag("init_list_done", init_list_done, row.exp_list_done);
		check_flag("bus_error", bus_error, row.exp_bus_err);
		check_count("tbl_update_done pulses", upd_pulses, int'(row.kind == pgwr_pkg::WK_ATT_UPD));
		check_idx("free_list_head", free_list_head, row.exp_list_done ? pgwr_pkg::idx_t'(1) : '0);
		check_idx("free_list_tail", free_list_tail,
		          row.exp_list_done ? pgwr_pkg::idx_t'(pgwr_pkg::LIST_ENTRY_CNT) : '0);
	endtask

	// bus side: ready stalls and in-order responses, one random stream
	initial begin
		int rsp_wait;
		awready  = 1'b0;
		wready   = 1'b0;
		bvalid   = 1'b0;
		bresp    = pgwr_pkg::OKAY;
		void'($urandom(32'h4e97d5d0));
		rsp_wait = 0;
		forever begin
			@(posedge clk_i);
			awready <= ($urandom % 4) != 0; // stall about one cycle in four
			wready  <= ($urandom % 4) != 0;
			bvalid  <= 1'b0;
			bresp   <= pgwr_pkg::OKAY;
			if (rsp_err.size() != 0) begin
				if (rsp_wait == 0) begin
					bvalid   <= 1'b1;
					bresp    <= rsp_err.pop_front() ? pgwr_pkg::SLVERR : pgwr_pkg::OKAY;
					rsp_wait = $urandom % 5; // gap before the next one
				end else begin
					rsp_wait--;
				end
			end
		end
	end

	// monitor, sampled mid-cycle where everything is settled
	always @(negedge clk_i) begin
		if (rst_ni) begin
			if (awvalid && awready) aw_addr = addr;
			if (wvalid && wready) begin
				store_beat(aw_addr, data, strb);
				rsp_err.push_back(force_err); // answered later
			end
			if (tbl_update_done) upd_pulses++;
			if (ready && rsp_err.size() != 0) begin
				n_other++;
				$display("Error at %0t: ready rose with %0d responses pending", $time, rsp_err.size());
			end
		end
	end

	initial begin
		repeat (WDOG_CYCLES) @(posedge clk_i);
		$display("Timeout at %0t: run did not finish within %0d cycles", $time, WDOG_CYCLES);
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		int r;
		rst_ni      = 1'b0;
		init_att    = 1'b0;
		init_list   = 1'b0;
		att_upd     = 1'b0;
		att_upd_id  = '0;
		att_upd_sts = pgwr_pkg::STS_DALLOC;
		att_upd_way = '0;
		att_upd_zpd = '0;
		force_err   = 1'b0;
		aw_addr     = '0;
		upd_pulses  = 0;
		n_mismatch  = 0;
		n_other     = 0;
		init_shadow();
		ops[0] = make_row(pgwr_pkg::WK_ATT_INIT, 0, pgwr_pkg::STS_DALLOC, '0, '0, 4'b0100);
		ops[1] = make_row(pgwr_pkg::WK_LIST_INIT, 0, pgwr_pkg::STS_DALLOC, '0, '0, 4'b0110);
		ops[2] = make_row(pgwr_pkg::WK_ATT_UPD, 3, pgwr_pkg::STS_COMP, 50'h1_2345_6789_abcd,
		                  12'h0a5, 4'b0110);
		ops[3] = make_row(pgwr_pkg::WK_ATT_UPD, 16, pgwr_pkg::STS_INCOMP, 50'h3_ffff_0000_1111,
		                  12'hfff, 4'b0110);
		ops[4] = make_row(pgwr_pkg::WK_ATT_UPD, 9, pgwr_pkg::STS_COMP, 50'h0_00c0_ffee_0042,
		                  12'h123, 4'b1111); // SLVERR on this one
		ops[5] = make_row(pgwr_pkg::WK_ATT_UPD, 1, pgwr_pkg::STS_DALLOC, '0, '0, 4'b0111);
		repeat (4) @(posedge clk_i);
		rst_ni <= 1'b1;
		@(negedge clk_i);
		check_flag("ready", ready, 1'b1); // reset values
		check_flag("awvalid", awvalid, 1'b0);
		check_flag("wvalid", wvalid, 1'b0);
		check_flag("init_att_done", init_att_done, 1'b0);
		check_flag("init_list_done", init_list_done, 1'b0);
		check_flag("tbl_update_done", tbl_update_done, 1'b0);
		check_flag("bus_error", bus_error, 1'b0);
		check_idx("free_list_head", free_list_head, '0);
		check_idx("free_list_tail", free_list_tail, '0);
		for (r = 0; r < N_OPS; r++) begin
			run_op(ops[r]);
			check_row(ops[r]);
		end
		$display("mismatches: %0d, other errors: %0d", n_mismatch, n_other);
		if (n_mismatch == 0 && n_other == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== sim/pgwr_assert.sv ====
// handshake assertions on the table write channel
// bound into the page-write manager top
`timescale 1ns/1ps

module pgwr_assert (
	input logic            clk_i,
	input logic            rst_ni,
	input logic            awvalid,
	input logic            awready,
	input logic            wvalid,
	input logic            ready,
	input pgwr_pkg::addr_t addr
);

	// address phase holds until accepted
	aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
		awvalid && !awready |=> awvalid && $stable(addr))
		else $error("awvalid dropped or addr changed before acceptance");

	// one channel at a time
	aw_w_excl: assert property (@(posedge clk_i) disable iff (!rst_ni) !(awvalid && wvalid))
		else $error("awvalid and wvalid high together");

	idle_no_aw: assert property (@(posedge clk_i) disable iff (!rst_ni) !(ready && awvalid))
		else $error("awvalid high while ready");

endmodule

bind pgwr_mngr pgwr_assert i_assert (.clk_i, .rst_ni, .awvalid, .awready, .wvalid, .ready, .addr);

// ==== rtl/pgwr_mngr.sv ====
// page-write manager top: att init, list init and att update writes
// sequencer, entry counter, beat register and response tracker
`timescale 1ns/1ps

module pgwr_mngr (
	input  logic                 clk_i,
	input  logic                 rst_ni,
	input  logic                 init_att,
	input  logic                 init_list,
	input  logic                 att_upd,
	input  pgwr_pkg::idx_t       att_upd_id,
	input  pgwr_pkg::att_sts_e   att_upd_sts,
	input  pgwr_pkg::way_t       att_upd_way,
	input  pgwr_pkg::zpd_t       att_upd_zpd,
	input  logic                 awready,
	input  logic                 wready,
	input  logic                 bvalid,
	input  pgwr_pkg::bresp_e     bresp,
	output logic                 awvalid,
	output logic                 wvalid,
	output pgwr_pkg::addr_t      addr,
	output pgwr_pkg::line_t      data,
	output pgwr_pkg::strb_t      strb,
	output logic                 ready,
	output logic                 init_att_done,
	output logic                 init_list_done,
	output logic                 tbl_update_done,
	output pgwr_pkg::idx_t       free_list_head,
	output pgwr_pkg::idx_t       free_list_tail,
	output logic                 bus_error
);
	tbl_wr_if wr ();

	logic               load;      // build next beat
	logic               start;     // rewind counter
	logic               last;      // current entry is the final one
	logic               idle_resp; // nothing outstanding
	pgwr_pkg::wr_kind_e kind;
	pgwr_pkg::idx_t     idx;

	// bus side of the write channel
	assign wr.awready = awready;
	assign wr.wready  = wready;
	assign awvalid    = wr.awvalid;
	assign wvalid     = wr.wvalid;
	assign addr       = wr.addr;
	assign data       = wr.data;
	assign strb       = wr.strb;

	pgwr_fsm i_fsm (
		.clk_i,
		.rst_ni,
		.init_att,
		.init_list,
		.att_upd,
		.last,
		.idle_resp,
		.load,
		.kind,
		.start,
		.ready,
		.init_att_done,
		.init_list_done,
		.tbl_update_done,
		.free_list_head,
		.free_list_tail,
		.wr (wr.ctrl)
	);

	entry_counter i_cnt (.clk_i, .rst_ni, .start, .load, .kind, .idx, .last);

	tbl_beat_builder i_beat (
		.clk_i,
		.rst_ni,
		.load,
		.kind,
		.idx,
		.att_upd_id,
		.att_upd_sts,
		.att_upd_way,
		.att_upd_zpd,
		.wr (wr.beat)
	);

	bresp_tracker i_resp (.clk_i, .rst_ni, .wr (wr.mon), .bvalid, .bresp, .idle_resp, .bus_error);

endmodule

// ==== pgwr/pgwr_fsm.sv ====
// operation sequencer: picks a request, issues one write per entry, drains responses
// owns the sticky done flags and the free list head/tail
`timescale 1ns/1ps

module pgwr_fsm (
	input  logic               clk_i,
	input  logic               rst_ni,
	input  logic               init_att,
	input  logic               init_list,
	input  logic               att_upd,
	input  logic               last,
	input  logic               idle_resp,
	output logic               load,
	output pgwr_pkg::wr_kind_e kind,
	output logic               start,
	output logic               ready,
	output logic               init_att_done,
	output logic               init_list_done,
	output logic               tbl_update_done,
	output pgwr_pkg::idx_t     free_list_head,
	output pgwr_pkg::idx_t     free_list_tail,
	tbl_wr_if.ctrl             wr
);
	typedef enum logic [2:0] {
		IDLE,
		LOAD,  // register next beat
		ADDR,  // awvalid up
		DATA,  // wvalid up
		DRAIN  // wait for all responses
	} state_e;

	state_e             state_q, state_d;
	pgwr_pkg::wr_kind_e kind_q, kind_d;
	logic               last_q; // beat in flight is the final one
	logic               op_end;

	always_comb begin
		state_d = state_q;
		kind_d  = kind_q;
		start   = 1'b0;
		load    = 1'b0;
		unique case (state_q)
			IDLE: begin
				// init_att first, then init_list, then updates
				if (init_att && !init_att_done) begin
					kind_d  = pgwr_pkg::WK_ATT_INIT;
					start   = 1'b1;
					state_d = LOAD;
				end else if (init_list && !init_list_done) begin
					kind_d  = pgwr_pkg::WK_LIST_INIT;
					start   = 1'b1;
					state_d = LOAD;
				end else if (att_upd) begin
					kind_d  = pgwr_pkg::WK_ATT_UPD;
					start   = 1'b1;
					state_d = LOAD;
				end
			end
			LOAD: begin
				load    = 1'b1; // counter steps here too
				state_d = ADDR;
			end
			ADDR: begin
				if (wr.awready) begin
					state_d = DATA;
				end
			end
			DATA: begin
				if (wr.wready) begin
					state_d = last_q ? DRAIN : LOAD;
				end
			end
			DRAIN: begin
				if (idle_resp) begin
					state_d = IDLE;
				end
			end
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q <= IDLE;
			kind_q  <= pgwr_pkg::WK_ATT_INIT;
			last_q  <= 1'b0;
		end else begin
			state_q <= state_d;
			kind_q  <= kind_d;
			if (load) begin
				last_q <= last; // sampled before the counter steps
			end
		end
	end

	assign op_end = (state_q == DRAIN) && idle_resp;

	// done flags and free list pointers
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			init_att_done  <= 1'b0;
			init_list_done <= 1'b0;
			free_list_head <= '0;
			free_list_tail <= '0;
		end else if (op_end) begin
			if (kind_q == pgwr_pkg::WK_ATT_INIT) begin
				init_att_done <= 1'b1;
			end
			if (kind_q == pgwr_pkg::WK_LIST_INIT) begin
				init_list_done <= 1'b1;
				free_list_head <= pgwr_pkg::idx_t'(1); // whole table is one free list
				free_list_tail <= pgwr_pkg::idx_t'(pgwr_pkg::LIST_ENTRY_CNT);
			end
		end
	end

	assign tbl_update_done = op_end && (kind_q == pgwr_pkg::WK_ATT_UPD); // one-cycle pulse
	assign ready           = (state_q == IDLE);
	assign kind            = kind_q;
	assign wr.awvalid      = (state_q == ADDR);
	assign wr.wvalid       = (state_q == DATA); // only after address accepted

endmodule

// ==== pgwr/bresp_tracker.sv ====
// outstanding write counter and sticky bus error flag
// responses arrive in order and are always accepted
`timescale 1ns/1ps

module bresp_tracker (
	input  logic             clk_i,
	input  logic             rst_ni,
	tbl_wr_if.mon            wr,
	input  logic             bvalid,
	input  pgwr_pkg::bresp_e bresp,
	output logic             idle_resp,
	output logic             bus_error
);
	logic [pgwr_pkg::OUTST_W-1:0] outst_q;
	logic                         aw_hs;     // address accepted
	logic                         rsp_unexp; // response with nothing pending
	logic                         retire;

	assign aw_hs     = wr.awvalid && wr.awready;
	assign rsp_unexp = bvalid && (outst_q == '0);
	assign retire    = bvalid && !rsp_unexp; // error or not, the write is answered

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			outst_q   <= '0;
			bus_error <= 1'b0;
		end else begin
			unique case ({aw_hs, retire})
				2'b10:   outst_q <= outst_q + 1'b1;
				2'b01:   outst_q <= outst_q - 1'b1;
				default: outst_q <= outst_q; // none or both
			endcase
			if ((bvalid && bresp != pgwr_pkg::OKAY) || rsp_unexp) begin
				bus_error <= 1'b1; // sticky until reset
			end
		end
	end

	assign idle_resp = (outst_q == '0);

endmodule

// ==== pgwr/tbl_beat_builder.sv ====
// write beat register: line address, one filled entry slot and its byte strobe
// att entries are 8 per line, list entries 4 per line
`timescale 1ns/1ps

module tbl_beat_builder (
	input  logic               clk_i,
	input  logic               rst_ni,
	input  logic               load,
	input  pgwr_pkg::wr_kind_e kind,
	input  pgwr_pkg::idx_t     idx,
	input  pgwr_pkg::idx_t     att_upd_id,
	input  pgwr_pkg::att_sts_e att_upd_sts,
	input  pgwr_pkg::way_t     att_upd_way,
	input  pgwr_pkg::zpd_t     att_upd_zpd,
	tbl_wr_if.beat             wr
);
	pgwr_pkg::idx_t                  ent;      // zero-based entry
	logic [pgwr_pkg::ATT_SLOT_W-1:0] att_slot;
	logic [pgwr_pkg::LST_SLOT_W-1:0] lst_slot;
	pgwr_pkg::att_entry_t            att_e;
	pgwr_pkg::list_entry_t           lst_e;
	pgwr_pkg::addr_t                 addr_d, addr_q;
	pgwr_pkg::line_t                 data_d, data_q;
	pgwr_pkg::strb_t                 strb_d, strb_q;

	// update targets its own id, inits walk the counter
	assign ent      = (kind == pgwr_pkg::WK_ATT_UPD) ? att_upd_id - 1'b1 : idx - 1'b1;
	assign att_slot = ent[pgwr_pkg::ATT_SLOT_W-1:0];
	assign lst_slot = ent[pgwr_pkg::LST_SLOT_W-1:0];

	always_comb begin
		att_e         = '0;
		att_e.sts     = pgwr_pkg::STS_DALLOC; // unmapped page
		if (kind == pgwr_pkg::WK_ATT_UPD) begin
			att_e.zpd_cnt = att_upd_zpd;
			att_e.way     = att_upd_way;
			att_e.sts     = att_upd_sts;
		end else if (pgwr_pkg::PWRUP_UNCOMP &&
		             idx <= pgwr_pkg::idx_t'(pgwr_pkg::LIST_ENTRY_CNT)) begin
			att_e.sts = pgwr_pkg::STS_UNCOMP;
			att_e.way = pgwr_pkg::PPA_BASE + pgwr_pkg::way_t'(ent); // identity mapped
		end
	end

	// one long free list, entry i links i-1 and i+1
	always_comb begin
		lst_e        = '0;
		lst_e.way    = pgwr_pkg::PPA_BASE + pgwr_pkg::way_t'(ent);
		lst_e.prev   = pgwr_pkg::ptr_t'(ent); // 0 for the head
		if (idx == pgwr_pkg::idx_t'(pgwr_pkg::LIST_ENTRY_CNT)) begin
			lst_e.next = '0; // tail points to null
		end else begin
			lst_e.next = pgwr_pkg::ptr_t'(idx) + 1'b1;
		end
	end

	always_comb begin
		data_d = '0;
		strb_d = '0;
		if (kind == pgwr_pkg::WK_LIST_INIT) begin
			addr_d = pgwr_pkg::LIST_BASE +
			         (pgwr_pkg::addr_t'(ent >> pgwr_pkg::LST_SLOT_W) << pgwr_pkg::LINE_SHIFT);
			data_d[lst_slot*pgwr_pkg::LST_BITS +: pgwr_pkg::LST_BITS]   = lst_e;
			strb_d[lst_slot*pgwr_pkg::LST_BYTES +: pgwr_pkg::LST_BYTES] = '1;
		end else begin
			addr_d = pgwr_pkg::ATT_BASE +
			         (pgwr_pkg::addr_t'(ent >> pgwr_pkg::ATT_SLOT_W) << pgwr_pkg::LINE_SHIFT);
			data_d[att_slot*pgwr_pkg::ATT_BITS +: pgwr_pkg::ATT_BITS]   = att_e;
			strb_d[att_slot*pgwr_pkg::ATT_BYTES +: pgwr_pkg::ATT_BYTES] = '1;
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			addr_q <= '0;
			strb_q <= '0;
		end else if (load) begin
			addr_q <= addr_d;
			strb_q <= strb_d;
		end
	end

	always_ff @(posedge clk_i) begin
		if (load) begin
			data_q <= data_d; // other slots stay zero
		end
	end

	assign wr.addr = addr_q;
	assign wr.data = data_q;
	assign wr.strb = strb_q;

endmodule

// ==== pgwr/entry_counter.sv ====
// entry index walker for table writes
// flags the final entry of the current operation
`timescale 1ns/1ps

module entry_counter (
	input  logic               clk_i,
	input  logic               rst_ni,
	input  logic               start,
	input  logic               load,
	input  pgwr_pkg::wr_kind_e kind,
	output pgwr_pkg::idx_t     idx,
	output logic               last
);

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			idx <= '0; // null
		end else if (start) begin
			idx <= pgwr_pkg::idx_t'(1); // first valid entry
		end else if (load) begin
			idx <= idx + 1'b1;
		end
	end

	always_comb begin
		unique case (kind)
			pgwr_pkg::WK_ATT_INIT: begin
				last = (idx == pgwr_pkg::idx_t'(pgwr_pkg::ATT_ENTRY_CNT));
			end
			pgwr_pkg::WK_LIST_INIT: begin
				last = (idx == pgwr_pkg::idx_t'(pgwr_pkg::LIST_ENTRY_CNT));
			end
			default: begin
				last = 1'b1; // update is a single write
			end
		endcase
	end

endmodule

// ==== common/tbl_wr_if.sv ====
// single-beat table write channel: address and data handshakes with payload
// modports for the sequencer, the beat register and the response monitor
`timescale 1ns/1ps

interface tbl_wr_if;
	logic awvalid;
	logic awready;
	logic wvalid;
	logic wready;
	pgwr_pkg::addr_t addr; // line address
	pgwr_pkg::line_t data; // one slot filled per beat
	pgwr_pkg::strb_t strb; // byte lanes of that slot

	// sequencer owns the valids
	modport ctrl (
		output awvalid,
		output wvalid,
		input  awready,
		input  wready
	);

	// payload register
	modport beat (
		output addr,
		output data,
		output strb
	);

	// observes everything
	modport mon (
		input awvalid,
		input awready,
		input wvalid,
		input wready,
		input addr,
		input data,
		input strb
	);
endinterface

// ==== common/pgwr_pkg.sv ====
// table sizes, base addresses and line layout for the page-write manager
// entry structs, status and opcode enums, bus response codes
package pgwr_pkg;

	// table sizes
	localparam int ATT_ENTRY_CNT  = 16;
	localparam int LIST_ENTRY_CNT = 8;
	localparam int ATT_PER_LINE   = 8;  // 64-bit entries per line
	localparam int LST_PER_LINE   = 4;  // 128-bit entries per line

	// index 0 is null, valid entries start at 1
	localparam int IDX_W = $clog2(ATT_ENTRY_CNT + 1);

	// line geometry
	localparam int LINE_BYTES = 64;
	localparam int LINE_SHIFT = $clog2(LINE_BYTES);
	localparam int ATT_BYTES  = LINE_BYTES / ATT_PER_LINE;
	localparam int LST_BYTES  = LINE_BYTES / LST_PER_LINE;
	localparam int ATT_BITS   = ATT_BYTES * 8;
	localparam int LST_BITS   = LST_BYTES * 8;
	localparam int ATT_SLOT_W = $clog2(ATT_PER_LINE);
	localparam int LST_SLOT_W = $clog2(LST_PER_LINE);

	// entry field widths
	localparam int WAY_W = 50;
	localparam int ZPD_W = 12;
	localparam int PTR_W = 24;

	localparam int OUTST_W = 4; // outstanding write counter

	typedef logic [IDX_W-1:0]      idx_t;
	typedef logic [WAY_W-1:0]      way_t;
	typedef logic [ZPD_W-1:0]      zpd_t;
	typedef logic [PTR_W-1:0]      ptr_t;
	typedef logic [8*LINE_BYTES-1:0] line_t;
	typedef logic [LINE_BYTES-1:0] strb_t;
	typedef logic [63:0]           addr_t;

	// table placement
	localparam addr_t ATT_BASE  = 64'h0000_0000_8000_0000;
	localparam addr_t LIST_BASE = 64'h0000_0000_8001_0000;
	localparam way_t  PPA_BASE  = 50'h0_0000_0009_0000; // first physical page number

	// att init marks the first LIST_ENTRY_CNT pages uncompressed
	localparam bit PWRUP_UNCOMP = 1'b1;

	typedef enum logic [1:0] {
		STS_DALLOC = 2'd0,
		STS_UNCOMP = 2'd1,
		STS_COMP   = 2'd2,
		STS_INCOMP = 2'd3
	} att_sts_e;

	typedef struct packed {
		zpd_t     zpd_cnt;
		way_t     way;
		att_sts_e sts;
	} att_entry_t;

	typedef struct packed {
		logic [5:0] rsvd;
		way_t       way;
		ptr_t       att_id;
		ptr_t       prev;
		ptr_t       next;
	} list_entry_t;

	typedef enum logic [1:0] {
		WK_ATT_INIT  = 2'd0,
		WK_LIST_INIT = 2'd1,
		WK_ATT_UPD   = 2'd2
	} wr_kind_e;

	// anything but OKAY is an error
	typedef enum logic [1:0] {
		OKAY   = 2'd0,
		EXOKAY = 2'd1,
		SLVERR = 2'd2,
		DECERR = 2'd3
	} bresp_e;

endpackage
